//--- verilog/axil_defs.svh
// Bus widths, RAM depth, memory latency and AXI response codes
`ifndef AXIL_DEFS_SVH
`define AXIL_DEFS_SVH

// ----------------------------------------------------------------------
// Internal AXI-lite bus geometry
// ----------------------------------------------------------------------
`define AXIL_ADDR_W 32                  // Byte address
`define AXIL_DATA_W 64                  // One memory word
`define AXIL_STRB_W (`AXIL_DATA_W / 8)  // One enable per byte
`define AXIL_RESP_W 2

// ----------------------------------------------------------------------
// Memory array
// ----------------------------------------------------------------------
`define RAM_DEPTH   256  // 64-bit words, byte range 0..2047
`define MEM_LATENCY 3    // Cycles from access accept to response

// Response codes
`define RESP_OKAY   2'b00
`define RESP_SLVERR 2'b10

`endif

//--- verilog/axil_pkg.sv
// AXI-lite bus vector types for address, data, strobe and response
`include "axil_defs.svh"

package axil_pkg;

  // ----------------------------------------------------------------------
  // Payload vectors of the internal bus
  // ----------------------------------------------------------------------

  // Byte address, also used on the processor port
  typedef logic [`AXIL_ADDR_W-1:0] addr_t;

  // One data word
  typedef logic [`AXIL_DATA_W-1:0] data_t;

  // Byte enables, bit n covers data bits 8n+7..8n
  typedef logic [`AXIL_STRB_W-1:0] strb_t;

  typedef logic [`AXIL_RESP_W-1:0] resp_t;  // OKAY or SLVERR only

endpackage

//--- verilog/ctrl_pkg.sv
// State machine enums for the master read path, master write path and slave
package ctrl_pkg;

  // Master read path
  typedef enum logic [1:0] {
    RD_IDLE, RD_ADDR, RD_DATA
  } rd_state_e;

  // Master write path
  typedef enum logic [1:0] {
    WR_IDLE, WR_ADDR, WR_DATA, WR_RESP
  } wr_state_e;

  // Slave controller, shared by both directions
  typedef enum logic [1:0] {
    SLV_IDLE, SLV_WDATA, SLV_WAIT, SLV_RESP
  } slv_state_e;

endpackage

//--- verilog/access_timer.sv
// Down-counter timing the fixed latency of the memory array
`timescale 1ns/1ps

module access_timer #(
  parameter int LATENCY = 3  // At least 1
) (
  input  logic i_aclk,
  input  logic i_rst_n,
  input  logic i_start,
  output logic o_done
);
  localparam int CNT_W = $clog2(LATENCY + 1);

  logic [CNT_W-1:0] cnt;  // Zero when idle

  always_ff @(posedge i_aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      cnt <= '0;
    end else if (i_start) begin
      cnt <= CNT_W'(LATENCY);
    end else if (cnt != '0) begin
      cnt <= cnt - 1'b1;
    end
  end

  // Last count, LATENCY cycles after the start pulse
  assign o_done = (cnt == CNT_W'(1));

  a_no_restart: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    i_start |-> (cnt == '0));

endmodule

//--- verilog/ram_bank.sv
// Byte-strobed word memory with range decode and zero data for unmapped reads
`timescale 1ns/1ps
`include "axil_defs.svh"

module ram_bank #(
  parameter int DEPTH = 256
) (
  input  logic             i_aclk,
  input  axil_pkg::addr_t  i_addr,
  input  logic             i_we,
  input  axil_pkg::data_t  i_wdata,
  input  axil_pkg::strb_t  i_strb,
  output axil_pkg::data_t  o_rdata,
  output logic             o_hit
);
  import axil_pkg::*;

  localparam int IDX_W = $clog2(DEPTH);

  data_t                  mem [DEPTH];
  logic [`AXIL_ADDR_W-4:0] word_idx;  // Byte address / 8

  initial begin
    for (int i = 0; i < DEPTH; i++) begin
      mem[i] = '0;
    end
  end

  assign word_idx = i_addr[`AXIL_ADDR_W-1:3];
  assign o_hit    = (word_idx < DEPTH);

  // Strobed bytes only
  always_ff @(posedge i_aclk) begin
    if (i_we) begin
      for (int b = 0; b < `AXIL_STRB_W; b++) begin
        if (i_strb[b]) begin
          mem[word_idx[IDX_W-1:0]][8*b +: 8] <= i_wdata[8*b +: 8];
        end
      end
    end
  end

  assign o_rdata = o_hit ? mem[word_idx[IDX_W-1:0]] : '0;

endmodule

//--- verilog/axil_slave_ctrl.sv
// AXI-lite slave FSM sequencing address, write data, latency wait and response
`timescale 1ns/1ps
`include "axil_defs.svh"

module axil_slave_ctrl (
  input  logic             i_aclk,
  input  logic             i_rst_n,
  // Internal bus, master outputs
  input  logic             i_awvalid,
  input  axil_pkg::addr_t  i_awaddr,
  input  logic             i_wvalid,
  input  axil_pkg::data_t  i_wdata,
  input  axil_pkg::strb_t  i_wstrb,
  input  logic             i_bready,
  input  logic             i_arvalid,
  input  axil_pkg::addr_t  i_araddr,
  input  logic             i_rready,
  // Internal bus, slave outputs
  output logic             o_awready,
  output logic             o_wready,
  output logic             o_bvalid,
  output axil_pkg::resp_t  o_bresp,
  output logic             o_arready,
  output logic             o_rvalid,
  output axil_pkg::data_t  o_rdata,
  output axil_pkg::resp_t  o_rresp,
  // RAM bank
  output axil_pkg::addr_t  o_ram_addr,
  output logic             o_ram_we,
  output axil_pkg::data_t  o_ram_wdata,
  output axil_pkg::strb_t  o_ram_strb,
  input  axil_pkg::data_t  i_ram_rdata,
  input  logic             i_ram_hit,
  // Latency timer
  output logic             o_timer_start,
  input  logic             i_timer_done
);
  import axil_pkg::*;
  import ctrl_pkg::*;

  slv_state_e state;
  logic       is_rd;    // Access in progress is a read
  addr_t      addr_q;
  data_t      rdata_q;
  resp_t      resp_q;
  logic       aw_fire, w_fire, b_fire, ar_fire, r_fire;

  // Reads win a tie in IDLE
  assign o_arready = (state == SLV_IDLE) && i_arvalid;
  assign o_awready = (state == SLV_IDLE) && i_awvalid && !i_arvalid;
  assign o_wready  = (state == SLV_WDATA);
  assign o_bvalid  = (state == SLV_RESP) && !is_rd;
  assign o_rvalid  = (state == SLV_RESP) && is_rd;

  assign aw_fire = i_awvalid & o_awready;
  assign w_fire  = i_wvalid  & o_wready;
  assign b_fire  = o_bvalid  & i_bready;
  assign ar_fire = i_arvalid & o_arready;
  assign r_fire  = o_rvalid  & i_rready;

  // ----------------------------------------------------------------------
  // Control FSM
  // ----------------------------------------------------------------------
  always_ff @(posedge i_aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state <= SLV_IDLE;
      is_rd <= 1'b0;
    end else begin
      case (state)
        SLV_IDLE: begin
          if (ar_fire) begin
            state <= SLV_WAIT;
            is_rd <= 1'b1;
          end else if (aw_fire) begin
            state <= SLV_WDATA;
            is_rd <= 1'b0;
          end
        end
        SLV_WDATA: if (w_fire) state <= SLV_WAIT;
        SLV_WAIT:  if (i_timer_done) state <= SLV_RESP;
        SLV_RESP:  if (b_fire || r_fire) state <= SLV_IDLE;
        default:   state <= SLV_IDLE;
      endcase
    end
  end

  // Address latch and registered response
  always_ff @(posedge i_aclk) begin
    if (ar_fire) begin
      addr_q <= i_araddr;
    end else if (aw_fire) begin
      addr_q <= i_awaddr;
    end
    if (state == SLV_WAIT && i_timer_done) begin
      resp_q  <= i_ram_hit ? `RESP_OKAY : `RESP_SLVERR;
      rdata_q <= i_ram_rdata;  // Zero when unmapped
    end
  end

  assign o_bresp = resp_q;
  assign o_rresp = resp_q;
  assign o_rdata = rdata_q;

  // ----------------------------------------------------------------------
  // RAM and timer drive
  // ----------------------------------------------------------------------
  assign o_ram_addr    = addr_q;
  assign o_ram_we      = w_fire && i_ram_hit;  // Unmapped writes dropped
  assign o_ram_wdata   = i_wdata;
  assign o_ram_strb    = i_wstrb;
  assign o_timer_start = ar_fire | w_fire;

  a_b_hold: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    o_bvalid && !i_bready |=> o_bvalid && $stable(o_bresp));
  a_r_hold: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    o_rvalid && !i_rready |=> o_rvalid && $stable(o_rdata) && $stable(o_rresp));

  // Master must not open the other direction mid-access
  a_one_access: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    (state != SLV_IDLE) |-> !(is_rd ? i_awvalid : i_arvalid));

endmodule

//--- verilog/axil_master.sv
// AXI-lite master for a held processor request, with read and write FSMs
`timescale 1ns/1ps
`include "axil_defs.svh"

module axil_master (
  input  logic             i_aclk,
  input  logic             i_rst_n,
  // Processor request port
  input  logic             i_rw_valid,
  input  logic             i_rw_ren,
  input  logic             i_rw_wen,
  input  axil_pkg::addr_t  i_rw_addr,
  input  axil_pkg::data_t  i_rw_wdata,
  input  axil_pkg::strb_t  i_rw_strb,
  output logic             o_rw_addr_ok,
  output logic             o_rw_data_ok,
  output axil_pkg::data_t  o_rw_rdata,
  output logic             o_rw_err,
  // Internal bus, master outputs
  output logic             o_awvalid,
  output axil_pkg::addr_t  o_awaddr,
  output logic             o_wvalid,
  output axil_pkg::data_t  o_wdata,
  output axil_pkg::strb_t  o_wstrb,
  output logic             o_bready,
  output logic             o_arvalid,
  output axil_pkg::addr_t  o_araddr,
  output logic             o_rready,
  // Internal bus, slave outputs
  input  logic             i_awready,
  input  logic             i_wready,
  input  logic             i_bvalid,
  input  axil_pkg::resp_t  i_bresp,
  input  logic             i_arready,
  input  logic             i_rvalid,
  input  axil_pkg::data_t  i_rdata,
  input  axil_pkg::resp_t  i_rresp
);
  import axil_pkg::*;
  import ctrl_pkg::*;

  rd_state_e rd_state;
  wr_state_e wr_state;
  resp_t     done_resp;
  logic      aw_fire, w_fire, b_fire, ar_fire, r_fire;

  assign aw_fire = o_awvalid & i_awready;
  assign w_fire  = o_wvalid  & i_wready;
  assign b_fire  = o_bready  & i_bvalid;
  assign ar_fire = o_arvalid & i_arready;
  assign r_fire  = o_rready  & i_rvalid;

  // ----------------------------------------------------------------------
  // State machines, each moves only under its own request type
  // ----------------------------------------------------------------------
  always_ff @(posedge i_aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      rd_state <= RD_IDLE;
    end else if (i_rw_valid && i_rw_ren) begin
      case (rd_state)
        RD_IDLE: rd_state <= RD_ADDR;
        RD_ADDR: if (ar_fire) rd_state <= RD_DATA;
        RD_DATA: if (r_fire) rd_state <= RD_IDLE;
        default: rd_state <= RD_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_state <= WR_IDLE;
    end else if (i_rw_valid && i_rw_wen) begin
      case (wr_state)
        WR_IDLE: wr_state <= WR_ADDR;
        WR_ADDR: if (aw_fire) wr_state <= WR_DATA;
        WR_DATA: if (w_fire) wr_state <= WR_RESP;
        WR_RESP: if (b_fire) wr_state <= WR_IDLE;
        default: wr_state <= WR_IDLE;
      endcase
    end
  end

  // ----------------------------------------------------------------------
  // Channel decode, payload straight from the held request
  // ----------------------------------------------------------------------
  assign o_awvalid = (wr_state == WR_ADDR);
  assign o_awaddr  = i_rw_addr;
  assign o_wvalid  = (wr_state == WR_DATA);
  assign o_wdata   = i_rw_wdata;
  assign o_wstrb   = i_rw_strb;
  assign o_bready  = (wr_state == WR_RESP);  // Never back-pressures B
  assign o_arvalid = (rd_state == RD_ADDR);
  assign o_araddr  = i_rw_addr;
  assign o_rready  = (rd_state == RD_DATA);

  // Processor handshakes
  assign o_rw_addr_ok = ar_fire | w_fire;
  assign o_rw_data_ok = r_fire | b_fire;
  assign o_rw_rdata   = i_rdata;
  assign done_resp    = r_fire ? i_rresp : i_bresp;
  assign o_rw_err     = o_rw_data_ok && (done_resp != `RESP_OKAY);

  // Requester presents one direction at a time
  a_one_dir: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    i_rw_valid |-> !(i_rw_ren && i_rw_wen));

  // Relies on the requester holding its request
  a_aw_hold: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    o_awvalid && !i_awready |=> o_awvalid && $stable(o_awaddr));
  a_ar_hold: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    o_arvalid && !i_arready |=> o_arvalid && $stable(o_araddr));

endmodule

//--- verilog/axil_mem_top.sv
// Top level joining the AXI-lite master, slave controller, timer and RAM bank
`timescale 1ns/1ps
`include "axil_defs.svh"

module axil_mem_top (
  input  logic             i_aclk,
  input  logic             i_rst_n,
  input  logic             i_rw_valid,
  input  logic             i_rw_ren,
  input  logic             i_rw_wen,
  input  axil_pkg::addr_t  i_rw_addr,
  input  axil_pkg::data_t  i_rw_wdata,
  input  axil_pkg::strb_t  i_rw_strb,
  output logic             o_rw_addr_ok,
  output logic             o_rw_data_ok,
  output axil_pkg::data_t  o_rw_rdata,
  output logic             o_rw_err
);
  import axil_pkg::*;

  // ----------------------------------------------------------------------
  // Internal AXI-lite bus
  // ----------------------------------------------------------------------
  logic  awvalid, awready, wvalid, wready, bvalid, bready;
  logic  arvalid, arready, rvalid, rready;
  addr_t awaddr, araddr;
  data_t wdata, rdata;
  strb_t wstrb;
  resp_t bresp, rresp;

  // Memory side
  addr_t ram_addr;
  data_t ram_wdata, ram_rdata;
  strb_t ram_strb;
  logic  ram_we, ram_hit, timer_start, timer_done;

  axil_master u_master (
    .i_aclk, .i_rst_n,
    .i_rw_valid, .i_rw_ren, .i_rw_wen, .i_rw_addr, .i_rw_wdata, .i_rw_strb,
    .o_rw_addr_ok, .o_rw_data_ok, .o_rw_rdata, .o_rw_err,
    .o_awvalid(awvalid), .o_awaddr(awaddr), .o_wvalid(wvalid), .o_wdata(wdata),
    .o_wstrb(wstrb), .o_bready(bready), .o_arvalid(arvalid), .o_araddr(araddr),
    .o_rready(rready), .i_awready(awready), .i_wready(wready), .i_bvalid(bvalid),
    .i_bresp(bresp), .i_arready(arready), .i_rvalid(rvalid), .i_rdata(rdata),
    .i_rresp(rresp)
  );

  axil_slave_ctrl u_slave (
    .i_aclk, .i_rst_n,
    .i_awvalid(awvalid), .i_awaddr(awaddr), .i_wvalid(wvalid), .i_wdata(wdata),
    .i_wstrb(wstrb), .i_bready(bready), .i_arvalid(arvalid), .i_araddr(araddr),
    .i_rready(rready), .o_awready(awready), .o_wready(wready), .o_bvalid(bvalid),
    .o_bresp(bresp), .o_arready(arready), .o_rvalid(rvalid), .o_rdata(rdata),
    .o_rresp(rresp), .o_ram_addr(ram_addr), .o_ram_we(ram_we),
    .o_ram_wdata(ram_wdata), .o_ram_strb(ram_strb), .i_ram_rdata(ram_rdata),
    .i_ram_hit(ram_hit), .o_timer_start(timer_start), .i_timer_done(timer_done)
  );

  access_timer #(.LATENCY(`MEM_LATENCY)) u_timer (
    .i_aclk, .i_rst_n, .i_start(timer_start), .o_done(timer_done)
  );

  ram_bank #(.DEPTH(`RAM_DEPTH)) u_ram (
    .i_aclk, .i_addr(ram_addr), .i_we(ram_we), .i_wdata(ram_wdata),
    .i_strb(ram_strb), .o_rdata(ram_rdata), .o_hit(ram_hit)
  );

endmodule

//--- testbench/tb_axil_mem.sv
// Random-stimulus testbench for the AXI-lite memory subsystem with a memory model
`timescale 1ns/1ps
`include "axil_defs.svh"

module tb_axil_mem;
  import axil_pkg::*;

  localparam int TIMEOUT_CYC = 200;
  localparam int MIX_COUNT   = 400;

  logic  aclk;
  logic  rst_n;
  logic  rw_valid, rw_ren, rw_wen;
  addr_t rw_addr;
  data_t rw_wdata;
  strb_t rw_strb;
  logic  rw_addr_ok, rw_data_ok, rw_err;
  data_t rw_rdata;

  logic [31:0] lfsr;
  data_t       model_mem [`RAM_DEPTH];
  bit          touched [`RAM_DEPTH];  // Words a write could reach
  int          check_cnt;
  int          err_cnt;
  int          test_err_base;

  axil_mem_top UUT (
    .i_aclk(aclk), .i_rst_n(rst_n), .i_rw_valid(rw_valid), .i_rw_ren(rw_ren),
    .i_rw_wen(rw_wen), .i_rw_addr(rw_addr), .i_rw_wdata(rw_wdata), .i_rw_strb(rw_strb),
    .o_rw_addr_ok(rw_addr_ok), .o_rw_data_ok(rw_data_ok), .o_rw_rdata(rw_rdata),
    .o_rw_err(rw_err)
  );

  initial begin
    aclk = 1'b0;
    forever #2 aclk = ~aclk;
  end

  // ----------------------------------------------------------------------
  // Random source and memory model
  // ----------------------------------------------------------------------
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);  // Taps 32,22,2,1
  endfunction

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      r = {r[62:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic data_t merge_bytes(input data_t old, input data_t nw, input strb_t strb);
    data_t r;
    r = old;
    for (int b = 0; b < 8; b++) begin
      if (strb[b]) begin
        r[8*b +: 8] = nw[8*b +: 8];
      end
    end
    return r;
  endfunction

  function automatic bit in_range(input addr_t addr);
    return addr < (`RAM_DEPTH * 8);  // Mapped bytes 0..2047
  endfunction

  task automatic check(input bit ok, input string msg);
    check_cnt++;
    assert (ok) else begin
      $display("CHECK FAILED at %0t ns: %s", $time, msg);
      err_cnt++;
    end
  endtask

  // One request on the processor port, held until o_rw_data_ok
  task automatic do_request(input bit is_wr, input addr_t addr, input data_t wdata,
                            input strb_t strb, output data_t rdata, output bit err);
    int cyc;
    int addr_oks;
    bit done;
    cyc = 0;
    addr_oks = 0;
    done = 1'b0;
    rdata = '0;
    err = 1'b0;
    @(posedge aclk);
    #1;
    rw_valid = 1'b1;
    rw_ren   = !is_wr;
    rw_wen   = is_wr;
    rw_addr  = addr;
    rw_wdata = wdata;
    rw_strb  = strb;
    while (!done && cyc < TIMEOUT_CYC) begin
      @(negedge aclk);  // Outputs settled mid-cycle
      cyc++;
      if (rw_addr_ok) begin
        addr_oks++;
      end
      if (rw_data_ok) begin
        done  = 1'b1;
        rdata = rw_rdata;
        err   = rw_err;
      end
    end
    if (!done) begin
      $display("Timeout: no o_rw_data_ok within %0d cycles for address %h", TIMEOUT_CYC, addr);
      $display("CHECKS FAILED");
      $finish;
    end else begin
      check(addr_oks == 1, $sformatf("%0d o_rw_addr_ok pulses for address %h", addr_oks, addr));
      @(posedge aclk);
      #1;
      rw_valid = 1'b0;
      rw_ren   = 1'b0;
      rw_wen   = 1'b0;
      @(negedge aclk);
      check(!rw_addr_ok && !rw_data_ok,
            $sformatf("handshake pulse after o_rw_data_ok for address %h", addr));
    end
  endtask

  task automatic write_word(input addr_t addr, input data_t data, input strb_t strb);
    data_t rd;
    bit    err;
    int    idx;
    do_request(1'b1, addr, data, strb, rd, err);
    check(err == !in_range(addr), $sformatf("write %h: o_rw_err is %0b", addr, err));
    if (in_range(addr)) begin
      idx = addr >> 3;
      model_mem[idx] = merge_bytes(model_mem[idx], data, strb);
      touched[idx] = 1'b1;
    end else begin
      touched[(addr >> 3) % `RAM_DEPTH] = 1'b1;  // Word a leaking write would alias onto
    end
  endtask

  task automatic read_word(input addr_t addr);
    data_t rd;
    data_t exp;
    bit    err;
    exp = in_range(addr) ? model_mem[addr >> 3] : '0;  // Unmapped reads give zero
    do_request(1'b0, addr, '0, '0, rd, err);
    check(err == !in_range(addr), $sformatf("read %h: o_rw_err is %0b", addr, err));
    check(rd == exp, $sformatf("read %h: got %h, expected %h", addr, rd, exp));
  endtask

  task automatic report_test(input string name);
    $display("Test %-12s finished, %0d errors", name, err_cnt - test_err_base);
    test_err_base = err_cnt;
  endtask

  // ----------------------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------------------
  initial begin
    addr_t a;
    data_t d;
    strb_t s;
    lfsr = 32'hd32ada6f;
    check_cnt = 0;
    err_cnt = 0;
    test_err_base = 0;
    for (int i = 0; i < `RAM_DEPTH; i++) begin
      model_mem[i] = '0;
      touched[i] = 1'b0;
    end
    rst_n    = 1'b0;
    rw_valid = 1'b0;
    rw_ren   = 1'b0;
    rw_wen   = 1'b0;
    rw_addr  = '0;
    rw_wdata = '0;
    rw_strb  = '0;

    repeat (8) begin
      @(negedge aclk);
      check(!rw_addr_ok && !rw_data_ok && !rw_err, "port outputs high during reset");
    end
    @(posedge aclk);
    #1;
    rst_n = 1'b1;
    repeat (3) begin
      @(negedge aclk);
      check(!rw_addr_ok && !rw_data_ok && !rw_err, "port outputs high after reset");
    end
    report_test("reset");

    d = rand_bits(64);
    write_word(32'h28, d, 8'hff);
    read_word(32'h28);
    report_test("full_write");

    a = addr_t'(rand_bits(8)) << 3;  // One word for all partial writes
    repeat (16) begin
      d = rand_bits(64);
      s = rand_bits(8);
      write_word(a, d, s);
      read_word(a);
    end
    report_test("strobe_merge");

    repeat (8) begin
      a = addr_t'(32'h800 + rand_bits(24));
      d = rand_bits(64);
      write_word(a, d, 8'hff);
      read_word(a);
    end
    write_word(32'hffff_fff8, '1, 8'hff);
    read_word(32'hffff_fff8);
    for (int i = 0; i < `RAM_DEPTH; i++) begin
      if (touched[i]) begin
        read_word(addr_t'(i * 8));
      end
    end
    report_test("unmapped");

    // Mostly in range, one in eight above the RAM
    repeat (MIX_COUNT) begin
      if (rand_bits(3) == 0) begin
        a = addr_t'(32'h800 + rand_bits(28));
      end else begin
        a = addr_t'(rand_bits(11));
      end
      if (rand_bits(1) == 1) begin
        d = rand_bits(64);
        s = rand_bits(8);
        write_word(a, d, s);
      end else begin
        read_word(a);
      end
    end
    report_test("random_mix");

    $display("Summary: %0d checks run, %0d errors", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- axil_mem.f
+incdir+verilog
verilog/axil_pkg.sv
verilog/ctrl_pkg.sv
verilog/access_timer.sv
verilog/ram_bank.sv
verilog/axil_slave_ctrl.sv
verilog/axil_master.sv
verilog/axil_mem_top.sv
testbench/tb_axil_mem.sv

//--- Bender.yml
package:
  name: axil_mem

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/axil_pkg.sv
      - verilog/ctrl_pkg.sv
      - verilog/access_timer.sv
      - verilog/ram_bank.sv
      - verilog/axil_slave_ctrl.sv
      - verilog/axil_master.sv
      - verilog/axil_mem_top.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - testbench/tb_axil_mem.sv
